//--- design/dbg_harness_pkg.sv
`default_nettype none

package dbg_harness_pkg;

    // DMI side
    localparam int unsigned DMI_ADDR_W = 7;
    localparam int unsigned DMI_DATA_W = 32;

    // System bus side
    localparam int unsigned BUS_ADDR_W = 16;
    localparam int unsigned BUS_DATA_W = 64;
    localparam int unsigned BUS_BE_W   = BUS_DATA_W / 8;

    // Data memory window
    localparam logic [BUS_ADDR_W-1:0] DMEM_BASE  = 16'h4000;
    localparam int unsigned           DMEM_WORDS = 512;
    localparam int unsigned           DMEM_AW    = $clog2(DMEM_WORDS);
    localparam int unsigned           DMEM_OFS   = $clog2(BUS_BE_W); // Byte offset bits
    localparam logic [BUS_ADDR_W-1:0] DMEM_LAST  =
        DMEM_BASE + BUS_ADDR_W'(DMEM_WORDS * BUS_BE_W - 1);

    // Lost access detection
    localparam int unsigned SBA_TIMEOUT = 16;
    localparam int unsigned SBA_CNT_W   = $clog2(SBA_TIMEOUT + 1);

    // DMI register map
    localparam logic [DMI_ADDR_W-1:0] ADDR_SBCS    = 7'h38;
    localparam logic [DMI_ADDR_W-1:0] ADDR_SBADDR  = 7'h39;
    localparam logic [DMI_ADDR_W-1:0] ADDR_SBDATA0 = 7'h3C;
    localparam logic [DMI_ADDR_W-1:0] ADDR_SBDATA1 = 7'h3D;

    localparam logic [2:0] SIZE_32     = 3'd2;
    localparam logic [2:0] ERR_NONE    = 3'd0;
    localparam logic [2:0] ERR_TIMEOUT = 3'd1;

    typedef enum logic [1:0] {
        DMI_NOP,
        DMI_READ,
        DMI_WRITE
    } dmi_op_e;

    typedef struct packed {
        dmi_op_e               op;
        logic [DMI_ADDR_W-1:0] addr;
        logic [DMI_DATA_W-1:0] data;
    } dmi_req_t;

    typedef struct packed {
        logic       busyerror;
        logic       busy;
        logic       readonaddr;
        logic [2:0] access;
        logic [2:0] error;
    } sbcs_t;

    typedef struct packed {
        logic                  we;
        logic [BUS_ADDR_W-1:0] addr;
        logic [BUS_BE_W-1:0]   be;
        logic [BUS_DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [BUS_DATA_W-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic                  start;
        logic                  write;
        logic [BUS_ADDR_W-1:0] addr;
        logic [2:0]            size;
        logic [BUS_DATA_W-1:0] data;
    } sba_cmd_t;

    typedef struct packed {
        logic                  done;
        logic                  err;
        logic [BUS_DATA_W-1:0] rdata;
    } sba_done_t;

endpackage

`default_nettype wire

//--- design/bus_stage.sv
`timescale 1ns/1ps
`default_nettype none

module bus_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= data_i; // Payload follows the input every cycle
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

//--- design/sba_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sba_timer import dbg_harness_pkg::*; (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic run_i,
    output logic expired_o
);

    logic [SBA_CNT_W-1:0] cnt_q;
    logic                 expired_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q     <= '0;
            expired_q <= 1'b0;
        end else if (!run_i) begin
            cnt_q     <= '0;
            expired_q <= 1'b0;
        end else begin
            if (cnt_q != SBA_CNT_W'(SBA_TIMEOUT)) cnt_q <= cnt_q + 1'b1; // Saturate
            expired_q <= (cnt_q == SBA_CNT_W'(SBA_TIMEOUT - 1));
        end
    end

    assign expired_o = expired_q;

endmodule

`default_nettype wire

//--- design/sba_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sba_fsm import dbg_harness_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  sba_cmd_t  cmd_i,
    output sba_done_t done_o,
    output logic      breq_valid_o,
    output bus_req_t  breq_o,
    input  logic      brsp_valid_i,
    input  bus_rsp_t  brsp_i,
    output logic      timer_run_o,
    input  logic      timer_expired_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_FINISH
    } state_e;

    state_e                state_q;
    state_e                state_d;
    bus_req_t              req_q;
    logic                  err_q;
    logic [BUS_DATA_W-1:0] rdata_q;
    logic [BUS_BE_W-1:0]   be;

    // Sub-word access selects one half of the word
    assign be = (cmd_i.size == SIZE_32) ? (cmd_i.addr[2] ? 8'hF0 : 8'h0F) : 8'hFF;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (cmd_i.start) state_d = S_ISSUE;
            S_ISSUE:  state_d = S_WAIT;
            S_WAIT:   if (brsp_valid_i || timer_expired_i) state_d = S_FINISH;
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && cmd_i.start) begin
            req_q <= '{we: cmd_i.write, addr: cmd_i.addr, be: be, wdata: cmd_i.data};
        end
        if (state_q == S_WAIT) begin
            if (brsp_valid_i) begin // Response wins over a late expiry
                err_q   <= 1'b0;
                rdata_q <= brsp_i.rdata;
            end else if (timer_expired_i) begin
                err_q   <= 1'b1;
                rdata_q <= '0;
            end
        end
    end

    assign breq_valid_o = (state_q == S_ISSUE);
    assign breq_o       = req_q;
    assign timer_run_o  = (state_q == S_WAIT);
    assign done_o       = '{done: (state_q == S_FINISH), err: err_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- design/sba_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sba_regs import dbg_harness_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  dmi_req_i,
    input  logic                  dmi_wr_i,
    input  logic [DMI_ADDR_W-1:0] dmi_addr_i,
    input  logic [DMI_DATA_W-1:0] dmi_wdata_i,
    output logic [DMI_DATA_W-1:0] dmi_rdata_o,
    output sba_cmd_t              cmd_o,
    input  sba_done_t             done_i
);

    dmi_req_t              dmi;
    sbcs_t                 sbcs_q;
    logic [BUS_ADDR_W-1:0] sbaddr_q;
    logic [DMI_DATA_W-1:0] sbdata0_q;
    logic [DMI_DATA_W-1:0] sbdata1_q;
    logic [DMI_DATA_W-1:0] rdata_q;
    logic [DMI_DATA_W-1:0] rd_mux;

    // Command held towards the FSM
    logic                  start_q;
    logic                  cmd_write_q;
    logic [BUS_ADDR_W-1:0] cmd_addr_q;
    logic [2:0]            cmd_size_q;
    logic [BUS_DATA_W-1:0] cmd_data_q;

    logic                  wr_en;
    logic                  bus_wr;
    logic                  busy_hit;
    logic                  start_wr;
    logic                  start_rd;
    logic                  launch;
    logic [BUS_ADDR_W-1:0] launch_addr;
    logic [BUS_DATA_W-1:0] launch_data;

    assign dmi.op   = dmi_req_i ? (dmi_wr_i ? DMI_WRITE : DMI_READ) : DMI_NOP;
    assign dmi.addr = dmi_addr_i;
    assign dmi.data = dmi_wdata_i;

    assign wr_en    = (dmi.op == DMI_WRITE);
    assign bus_wr   = wr_en && (dmi.addr == ADDR_SBADDR || dmi.addr == ADDR_SBDATA0 ||
                                dmi.addr == ADDR_SBDATA1);
    assign busy_hit = bus_wr && sbcs_q.busy;
    assign start_wr = wr_en && !sbcs_q.busy && (dmi.addr == ADDR_SBDATA0);
    assign start_rd = wr_en && !sbcs_q.busy && (dmi.addr == ADDR_SBADDR) && sbcs_q.readonaddr;
    assign launch   = start_wr || start_rd;

    // Reads take the fresh address, writes the stored one
    assign launch_addr = (dmi.addr == ADDR_SBADDR) ? dmi.data[BUS_ADDR_W-1:0] : sbaddr_q;

    always_comb begin
        if (sbcs_q.access == SIZE_32) begin
            launch_data = launch_addr[2] ? {dmi.data, {DMI_DATA_W{1'b0}}}
                                         : {{DMI_DATA_W{1'b0}}, dmi.data};
        end else begin
            launch_data = {sbdata1_q, dmi.data};
        end
    end

    always_comb begin
        rd_mux = '0;
        case (dmi.addr)
            ADDR_SBCS: begin // Debug spec bit positions
                rd_mux[22]    = sbcs_q.busyerror;
                rd_mux[21]    = sbcs_q.busy;
                rd_mux[20]    = sbcs_q.readonaddr;
                rd_mux[19:17] = sbcs_q.access;
                rd_mux[14:12] = sbcs_q.error;
            end
            ADDR_SBADDR:  rd_mux[BUS_ADDR_W-1:0] = sbaddr_q;
            ADDR_SBDATA0: rd_mux = sbdata0_q;
            ADDR_SBDATA1: rd_mux = sbdata1_q;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sbcs_q  <= '{error: ERR_NONE, default: '0};
            start_q <= 1'b0;
            rdata_q <= '0;
        end else begin
            start_q <= launch;
            if (done_i.done) begin
                sbcs_q.busy <= 1'b0;
                if (done_i.err) sbcs_q.error <= ERR_TIMEOUT;
            end
            if (launch) sbcs_q.busy <= 1'b1;
            if (busy_hit) sbcs_q.busyerror <= 1'b1;
            if (wr_en && dmi.addr == ADDR_SBCS) begin
                sbcs_q.readonaddr <= dmi.data[20];
                sbcs_q.access     <= dmi.data[19:17];
                if (dmi.data[22]) sbcs_q.busyerror <= 1'b0; // Write one to clear
                if (|dmi.data[14:12]) sbcs_q.error <= ERR_NONE;
            end
            if (dmi.op == DMI_READ) rdata_q <= rd_mux;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_wr && !sbcs_q.busy) begin
            case (dmi.addr)
                ADDR_SBADDR:  sbaddr_q  <= dmi.data[BUS_ADDR_W-1:0];
                ADDR_SBDATA0: sbdata0_q <= dmi.data;
                default:      sbdata1_q <= dmi.data;
            endcase
        end
        if (done_i.done && !done_i.err && !cmd_write_q) begin
            if (cmd_size_q == SIZE_32) begin
                sbdata0_q <= cmd_addr_q[2] ? done_i.rdata[63:32] : done_i.rdata[31:0];
            end else begin
                sbdata0_q <= done_i.rdata[31:0];
                sbdata1_q <= done_i.rdata[63:32];
            end
        end
        if (launch) begin
            cmd_write_q <= start_wr;
            cmd_addr_q  <= launch_addr;
            cmd_size_q  <= sbcs_q.access;
            cmd_data_q  <= launch_data;
        end
    end

    assign cmd_o = '{start: start_q, write: cmd_write_q, addr: cmd_addr_q,
                     size: cmd_size_q, data: cmd_data_q};
    assign dmi_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- design/dmem.sv
`timescale 1ns/1ps
`default_nettype none

module dmem import dbg_harness_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     rsp_valid_o,
    output bus_rsp_t rsp_o
);

    logic [BUS_DATA_W-1:0] mem [DMEM_WORDS];
    logic [DMEM_AW-1:0]    raddr_q;
    logic [DMEM_AW-1:0]    widx;
    logic                  in_win;
    logic                  rsp_valid_q;

    assign in_win = (req_i.addr >= DMEM_BASE) && (req_i.addr <= DMEM_LAST);
    assign widx   = req_i.addr[DMEM_OFS +: DMEM_AW];

    always_ff @(posedge clk_i) begin
        if (req_valid_i && in_win) begin
            if (req_i.we) begin
                for (int i = 0; i < BUS_BE_W; i++) begin
                    if (req_i.be[i]) mem[widx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
                end
            end else begin
                raddr_q <= widx; // Word read out of the registered index
            end
        end
    end

    // Writes answer too but only inside the window
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_valid_i && in_win;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o.rdata = mem[raddr_q];

endmodule

`default_nettype wire

//--- design/dbg_harness_top.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_harness_top import dbg_harness_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  dmi_req_i,
    input  logic                  dmi_wr_i,
    input  logic [DMI_ADDR_W-1:0] dmi_addr_i,
    input  logic [DMI_DATA_W-1:0] dmi_wdata_i,
    output logic [DMI_DATA_W-1:0] dmi_rdata_o
);

    sba_cmd_t  cmd;
    sba_done_t done;
    logic      breq_valid;
    bus_req_t  breq;
    logic      mreq_valid; // Request at the memory
    bus_req_t  mreq;
    logic      mrsp_valid; // Response out of the memory
    bus_rsp_t  mrsp;
    logic      brsp_valid;
    bus_rsp_t  brsp;
    logic      timer_run;
    logic      timer_expired;

    sba_regs i_sba_regs (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dmi_req_i   (dmi_req_i),
        .dmi_wr_i    (dmi_wr_i),
        .dmi_addr_i  (dmi_addr_i),
        .dmi_wdata_i (dmi_wdata_i),
        .dmi_rdata_o (dmi_rdata_o),
        .cmd_o       (cmd),
        .done_i      (done)
    );

    sba_fsm i_sba_fsm (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .cmd_i           (cmd),
        .done_o          (done),
        .breq_valid_o    (breq_valid),
        .breq_o          (breq),
        .brsp_valid_i    (brsp_valid),
        .brsp_i          (brsp),
        .timer_run_o     (timer_run),
        .timer_expired_i (timer_expired)
    );

    sba_timer i_sba_timer (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .run_i     (timer_run),
        .expired_o (timer_expired)
    );

    bus_stage #(.payload_t(bus_req_t)) i_req_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (breq_valid),
        .data_i   (breq),
        .valid_o  (mreq_valid),
        .data_o   (mreq)
    );

    dmem i_dmem (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (mreq_valid),
        .req_i       (mreq),
        .rsp_valid_o (mrsp_valid),
        .rsp_o       (mrsp)
    );

    bus_stage #(.payload_t(bus_rsp_t)) i_rsp_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (mrsp_valid),
        .data_i   (mrsp),
        .valid_o  (brsp_valid),
        .data_o   (brsp)
    );

endmodule

`default_nettype wire

//--- testbench/dbg_harness_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_harness_chk import dbg_harness_pkg::*; (
    input logic      clk_i,
    input logic      arst_n_i,
    input sba_done_t done_i,
    input logic [1:0] state_i,     // FSM state with zero as idle
    input logic      brsp_valid_i,
    input logic      req_valid_i,
    input bus_req_t  req_i,
    input logic      rsp_valid_i
);

    logic in_win;

    // Offset from the base stays below the window size
    assign in_win = (req_i.addr - DMEM_BASE) < BUS_ADDR_W'(DMEM_WORDS * BUS_BE_W);

    a_done_single: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) done_i.done |=> !done_i.done
    ) else $error("done pulse held for two cycles");

    a_no_rsp_idle: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) (state_i == 2'd0) |-> !brsp_valid_i
    ) else $error("bus response arrived while the FSM was idle");

    // Out of window requests must stay unanswered
    a_no_rsp_outside: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) (req_valid_i && !in_win) |=> !rsp_valid_i
    ) else $error("memory answered a request outside its window");

endmodule

bind sba_fsm dbg_harness_chk i_fsm_chk (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .done_i       (done_o),
    .state_i      (state_q),
    .brsp_valid_i (brsp_valid_i),
    .req_valid_i  (1'b0),
    .req_i        ('0),
    .rsp_valid_i  (1'b0)
);

bind dmem dbg_harness_chk i_dmem_chk (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .done_i       ('0),
    .state_i      (2'd0),
    .brsp_valid_i (1'b0),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .rsp_valid_i  (rsp_valid_o)
);

`default_nettype wire

//--- testbench/tb_dbg_harness.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_harness import dbg_harness_pkg::*; ();

    localparam logic [DMI_DATA_W-1:0] SBCS_FIELDS = 32'h007E_7000; // Defined sbcs bits
    localparam int POLL_LIMIT = 2 * (SBA_TIMEOUT + 8);

    typedef struct packed {
        logic [7:0]            op;
        logic [DMI_ADDR_W-1:0] addr;
        logic [DMI_DATA_W-1:0] data;
        logic [DMI_DATA_W-1:0] exp_data;
    } test_line_t;

    logic                  clk;
    logic                  arst_n;
    logic                  dmi_req;
    logic                  dmi_wr;
    logic [DMI_ADDR_W-1:0] dmi_addr;
    logic [DMI_DATA_W-1:0] dmi_wdata;
    logic [DMI_DATA_W-1:0] dmi_rdata;

    test_line_t  tests[$];
    int unsigned cycle_limit = 0;
    int unsigned cycles = 0;
    int          value_errors = 0;
    int          poll_errors = 0;
    int          other_errors = 0;

    dbg_harness_top i_dut (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .dmi_req_i   (dmi_req),
        .dmi_wr_i    (dmi_wr),
        .dmi_addr_i  (dmi_addr),
        .dmi_wdata_i (dmi_wdata),
        .dmi_rdata_o (dmi_rdata)
    );

    always #4 clk = ~clk;

    // Debug spec field positions of the status word
    function automatic sbcs_t sbcs_from_word(input logic [DMI_DATA_W-1:0] w);
        sbcs_t s;
        s.busyerror  = w[22];
        s.busy       = w[21];
        s.readonaddr = w[20];
        s.access     = w[19:17];
        s.error      = w[14:12];
        return s;
    endfunction

    function automatic string sbcs_text(input sbcs_t s);
        return $sformatf("busyerror=%b busy=%b readonaddr=%b size=%0d err=%0d",
                         s.busyerror, s.busy, s.readonaddr, s.access, s.error);
    endfunction

    function automatic string reg_name(input logic [DMI_ADDR_W-1:0] addr);
        case (addr)
            ADDR_SBADDR:  return "sbaddress0";
            ADDR_SBDATA0: return "sbdata0";
            ADDR_SBDATA1: return "sbdata1";
            default:      return $sformatf("dmi_reg_%h", addr);
        endcase
    endfunction

    task automatic check_rdata(input string name, input logic [DMI_DATA_W-1:0] got,
                               input logic [DMI_DATA_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sbcs(input sbcs_t got, input sbcs_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0d ns sbcs: got %s, expected %s", $time,
                     sbcs_text(got), sbcs_text(exp));
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same point of the next cycle
    task automatic dmi_write(input logic [DMI_ADDR_W-1:0] addr,
                             input logic [DMI_DATA_W-1:0] data);
        dmi_req   = 1'b1;
        dmi_wr    = 1'b1;
        dmi_addr  = addr;
        dmi_wdata = data;
        @(posedge clk);
        #1;
        dmi_req = 1'b0;
        dmi_wr  = 1'b0;
    endtask

    task automatic dmi_read(input logic [DMI_ADDR_W-1:0] addr,
                            output logic [DMI_DATA_W-1:0] data);
        dmi_req  = 1'b1;
        dmi_wr   = 1'b0;
        dmi_addr = addr;
        @(posedge clk);
        #1;
        dmi_req = 1'b0;
        data    = dmi_rdata; // Updated on the edge just passed
    endtask

    task automatic poll_idle();
        logic [DMI_DATA_W-1:0] word;
        sbcs_t                 status;
        int                    tries;
        tries = 0;
        do begin
            dmi_read(ADDR_SBCS, word);
            status = sbcs_from_word(word);
            tries++;
        end while (status.busy !== 1'b0 && tries < POLL_LIMIT);
        if (status.busy !== 1'b0) begin
            poll_errors++;
            $display("Bus access never finished: busy still set after %0d polls at %0d ns",
                     tries, $time);
        end
    endtask

    task automatic load_tests(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       op_s;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        test_line_t  t;
        ok = 1'b0;
        fd = $fopen("testbench/sba_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/sba_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h", op_s, a, d, e);
                    if (n == 4) begin
                        t.op       = op_s.getc(0);
                        t.addr     = a[DMI_ADDR_W-1:0];
                        t.data     = d;
                        t.exp_data = e;
                        tests.push_back(t);
                    end
                end
            end
            $fclose(fd);
            ok = (tests.size() > 0);
            if (!ok) $display("No test lines found in testbench/sba_tests.txt");
        end
    endtask

    task automatic run_tests();
        logic [DMI_DATA_W-1:0] word;
        foreach (tests[i]) begin
            case (tests[i].op)
                "W": dmi_write(tests[i].addr, tests[i].data);
                "R": begin
                    dmi_read(tests[i].addr, word);
                    if (tests[i].addr == ADDR_SBCS) begin
                        check_sbcs(sbcs_from_word(word), sbcs_from_word(tests[i].exp_data));
                        check_rdata("sbcs reserved bits", word & ~SBCS_FIELDS, '0);
                    end else begin
                        check_rdata(reg_name(tests[i].addr), word, tests[i].exp_data);
                    end
                end
                "P": poll_idle();
                default: begin
                    other_errors++;
                    $display("Unknown op on test line %0d", i + 1);
                end
            endcase
        end
    endtask

    // Budget grows with the number of test lines
    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped: tests did not end within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        bit loaded;
        clk       = 1'b0;
        arst_n    = 1'b0;
        dmi_req   = 1'b0;
        dmi_wr    = 1'b0;
        dmi_addr  = '0;
        dmi_wdata = '0;
        load_tests(loaded);
        if (!loaded) begin
            other_errors++;
        end else begin
            cycle_limit = tests.size() * (SBA_TIMEOUT + 8);
        end
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        if (loaded) run_tests();
        $display("Errors: %0d value mismatches, %0d unfinished polls, %0d other",
                 value_errors, poll_errors, other_errors);
        if (value_errors + poll_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
design/dbg_harness_pkg.sv
design/bus_stage.sv
design/sba_timer.sv
design/sba_fsm.sv
design/sba_regs.sv
design/dmem.sv
design/dbg_harness_top.sv
testbench/dbg_harness_chk.sv
testbench/tb_dbg_harness.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dbg_harness -f all.f > build.log 2>&1 \
    || { cat build.log; echo "Build error, see build.log"; exit 1; }
./obj_dir/Vtb_dbg_harness > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
grep -q "Test failed" sim.log && exit 1 || exit 0

//--- testbench/sba_tests.txt
# op: W dmi write, R dmi read and compare, P poll sbcs until busy clears
# columns: op dmi_addr wdata expected, all hex, unused columns 0
R 38 00000000 00000000
W 38 00060000 00000000
W 39 00004000 00000000
W 3D 89abcdef 00000000
W 3C 01234567 00000000
P 38 00000000 00000000
W 38 00160000 00000000
W 39 00004000 00000000
P 38 00000000 00000000
R 3C 00000000 01234567
R 3D 00000000 89abcdef
W 38 00040000 00000000
W 39 00004008 00000000
W 3C 11112222 00000000
P 38 00000000 00000000
W 39 0000400c 00000000
W 3C 33334444 00000000
P 38 00000000 00000000
W 38 00160000 00000000
W 39 00004008 00000000
P 38 00000000 00000000
R 3C 00000000 11112222
R 3D 00000000 33334444
W 38 00140000 00000000
W 39 00004004 00000000
P 38 00000000 00000000
R 3C 00000000 89abcdef
W 38 00160000 00000000
W 39 00001000 00000000
P 38 00000000 00000000
R 38 00000000 00161000
W 38 00167000 00000000
R 38 00000000 00160000
W 38 00060000 00000000
W 39 00004010 00000000
W 3D cafef00d 00000000
W 3C 01234567 00000000
W 3C deadbeef 00000000
P 38 00000000 00000000
R 38 00000000 00460000
W 38 00560000 00000000
R 38 00000000 00160000
W 39 00004010 00000000
P 38 00000000 00000000
R 3C 00000000 01234567
R 3D 00000000 cafef00d
R 39 00000000 00004010
